// ==== files.f ====
+incdir+verilog
verilog/lsu_pkg.sv
verilog/stage_reg.sv
verilog/addr_gen.sv
verilog/dcache_access.sv
verilog/load_align.sv
verilog/lsu_top.sv
tb/lsu_properties.sv
tb/lsu_tb.sv

// ==== tb/lsu_tb.sv ====
`default_nettype none

`include "lsu_cfg.svh"

module lsu_tb
  import lsu_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_random  = 300;
  // roughly 12 cycles per operation at worst plus the directed part and margin
  localparam int cycle_limit = num_random * 12 + 2400;

  logic          clk = 1'b0;
  logic          rst;
  logic          req_valid;
  lsu_req_t      req;
  logic          req_ready;
  axi_lite_req_t mem_req;
  axi_lite_rsp_t mem_rsp;
  logic          result_valid;
  lsu_result_t   result;

  logic [7:0] mem_bytes [1024];
  logic [7:0] mirror [1024];

  lsu_result_t exp_q[$];
  string       name_q[$];

  logic [`LSU_TAG_W-1:0] next_tag = '0;
  int unsigned ar_count = 0;
  int unsigned cycles = 0;
  int unsigned checks = 0;
  int unsigned errors = 0;

  lsu_top u_lsu_top (
    .clk          (clk),
    .rst          (rst),
    .req_valid    (req_valid),
    .req          (req),
    .req_ready    (req_ready),
    .mem_req      (mem_req),
    .mem_rsp      (mem_rsp),
    .result_valid (result_valid),
    .result       (result)
  );

  always #10 clk = ~clk;

  // upper address bits folded in so lines sharing an index read back differently
  function automatic logic [7:0] fill_byte(input int a);
    logic [31:0] x;
    x = a ^ (a >> 8) ^ 32'h5a;
    return x[7:0];
  endfunction

  function automatic logic [31:0] random_offset(input lsu_op_e op);
    case (op)
      lsu_lb, lsu_lbu, lsu_sb: return 32'($urandom_range(3, 0));
      lsu_lh, lsu_lhu, lsu_sh: return 32'($urandom_range(1, 0) * 2);
      default:                 return 32'h0;
    endcase
  endfunction

  // expected load value from the mirror bytes
  function automatic logic [31:0] expected_value(input lsu_op_e op, input logic [31:0] addr);
    logic [7:0] b0;
    logic [7:0] b1;
    logic [7:0] b2;
    logic [7:0] b3;
    b0 = mirror[addr[9:0]];
    b1 = mirror[addr[9:0] + 10'd1];
    b2 = mirror[addr[9:0] + 10'd2];
    b3 = mirror[addr[9:0] + 10'd3];
    case (op)
      lsu_lb:  return {{24{b0[7]}}, b0};
      lsu_lbu: return {24'h0, b0};
      lsu_lh:  return {{16{b1[7]}}, b1, b0};
      lsu_lhu: return {16'h0, b1, b0};
      default: return {b3, b2, b1, b0};
    endcase
  endfunction

  task automatic apply_store(input lsu_op_e op, input logic [31:0] addr, input logic [31:0] data);
    int bytes;
    bytes = (op == lsu_sb) ? 1 : ((op == lsu_sh) ? 2 : 4);
    for (int i = 0; i < bytes; i++) begin
      mirror[addr[9:0] + 10'(i)] = data[8*i +: 8];
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // base and immediate split at random around the address
  task automatic issue(input lsu_op_e op, input logic [31:0] addr, input logic [31:0] data,
                       input string name);
    int          off;
    lsu_result_t exp;
    off = int'($urandom_range(255, 0)) - 128;
    @(negedge clk);
    req_valid = 1'b1;
    req.op    = op;
    req.imm   = off[11:0];
    req.base  = addr - 32'(off);
    req.data  = data;
    req.tag   = next_tag;
    do @(posedge clk); while (!req_ready);
    if (op inside {lsu_sb, lsu_sh, lsu_sw}) begin
      apply_store(op, addr, data);
    end else begin
      exp.tag   = next_tag;
      exp.value = expected_value(op, addr);
      exp_q.push_back(exp);
      name_q.push_back(name);
    end
    next_tag = next_tag + 1'b1;
  endtask

  task automatic drain();
    @(negedge clk);
    req_valid = 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  // AXI4-Lite memory serving one transaction at a time
  always begin : axi_memory
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    @(negedge clk);
    if (!rst && mem_req.arvalid) begin
      idle_cycles($urandom_range(4, 0));
      addr = mem_req.araddr;
      mem_rsp.arready = 1'b1;
      @(negedge clk);
      mem_rsp.arready = 1'b0;
      ar_count++;
      idle_cycles($urandom_range(4, 0));
      mem_rsp.rdata = {mem_bytes[{addr[9:2], 2'd3}], mem_bytes[{addr[9:2], 2'd2}],
                       mem_bytes[{addr[9:2], 2'd1}], mem_bytes[{addr[9:2], 2'd0}]};
      mem_rsp.rvalid = 1'b1;
      while (!mem_req.rready) @(negedge clk);
      @(negedge clk);
      mem_rsp.rvalid = 1'b0;
    end else if (!rst && mem_req.awvalid) begin
      idle_cycles($urandom_range(4, 0));
      addr = mem_req.awaddr;
      mem_rsp.awready = 1'b1;
      @(negedge clk);
      mem_rsp.awready = 1'b0;
      idle_cycles($urandom_range(4, 0));
      wdata = mem_req.wdata;
      wstrb = mem_req.wstrb;
      mem_rsp.wready = 1'b1;
      @(negedge clk);
      mem_rsp.wready = 1'b0;
      for (int i = 0; i < 4; i++) begin
        if (wstrb[i]) begin
          mem_bytes[{addr[9:2], 2'(i)}] = wdata[8*i +: 8];
        end
      end
      idle_cycles($urandom_range(4, 0));
      mem_rsp.bvalid = 1'b1;
      while (!mem_req.bready) @(negedge clk);
      @(negedge clk);
      mem_rsp.bvalid = 1'b0;
    end
  end

  always @(negedge clk) begin : compare
    lsu_result_t exp;
    string       name;
    if (result_valid) begin
      checks++;
      assert (exp_q.size() != 0) else begin
        errors++;
        $display("result bus fired with no load outstanding, tag %0d", result.tag);
      end
      if (exp_q.size() != 0) begin
        exp  = exp_q.pop_front();
        name = name_q.pop_front();
        assert (result == exp) else begin
          errors++;
          $display("ERROR %s: expected tag %0d value %08h, actual tag %0d value %08h",
                   name, exp.tag, exp.value, result.tag, result.value);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("run stopped after %0d cycles with %0d loads still waiting, checks %0d errors %0d",
               cycles, exp_q.size(), checks, errors);
      $display("test failed");
      $finish;
    end
  end

  initial begin : stimulus
    logic [31:0] base;
    logic [31:0] addr;
    int unsigned ar_before;
    lsu_op_e     op;
    void'($urandom(32'h0db3_b2d8));
    rst       = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    mem_rsp   = '0;
    for (int a = 0; a < 1024; a++) begin
      mem_bytes[a] = fill_byte(a);
      mirror[a]    = fill_byte(a);
    end
    repeat (4) @(negedge clk);
    rst = 1'b0;

    // 0x040 holds positive bytes and 0x0c0 negative ones on the same index
    for (int b = 0; b < 2; b++) begin
      base = (b == 0) ? 32'h040 : 32'h0c0;
      for (int off = 0; off < 4; off++) begin
        issue(lsu_lb, base + off, '0, "load_ext");
        issue(lsu_lbu, base + off, '0, "load_ext");
        if (off % 2 == 0) begin
          issue(lsu_lh, base + off, '0, "load_ext");
          issue(lsu_lhu, base + off, '0, "load_ext");
        end
      end
      issue(lsu_lw, base, '0, "load_ext");
    end

    // first three stores go to uncached lines and the last three to cached ones
    for (int k = 0; k < 6; k++) begin
      op   = lsu_op_e'(int'(lsu_sb) + k % 3);
      addr = 32'h100 + 32'(8 * k) + random_offset(op);
      if (k >= 3) begin
        issue(lsu_lw, {addr[31:2], 2'b00}, '0, "store_merge");
      end
      issue(op, addr, $urandom(), "store_merge");
      issue(lsu_lw, {addr[31:2], 2'b00}, '0, "store_merge");
    end

    issue(lsu_lw, 32'h1f0, '0, "line_reuse");
    drain();
    ar_before = ar_count;
    issue(lsu_lhu, 32'h1f2, '0, "line_reuse");
    issue(lsu_lb, 32'h1f3, '0, "line_reuse");
    drain();
    checks++;
    assert (ar_count == ar_before) else begin
      errors++;
      $display("ERROR line_reuse: expected %0d AR handshakes, actual %0d", ar_before, ar_count);
    end

    // 64 words give four tags for each index
    for (int n = 0; n < num_random; n++) begin
      op   = lsu_op_e'($urandom_range(7, 0));
      addr = 32'($urandom_range(63, 0)) * 4 + random_offset(op);
      issue(op, addr, $urandom(), "random_mix");
    end
    // trailing load only returns once every earlier store has finished
    issue(lsu_lw, 32'h0, '0, "random_mix");
    drain();

    $display("checks %0d errors %0d assertion failures %0d",
             checks, errors, u_lsu_top.u_lsu_properties.fails);
    if (errors == 0 && u_lsu_top.u_lsu_properties.fails == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/lsu_properties.sv ====
`default_nettype none

module lsu_properties
  import lsu_pkg::*;
(
  input wire           clk,
  input wire           rst,
  input axi_lite_req_t mem_req,
  input axi_lite_rsp_t mem_rsp,
  input wire           result_valid
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fails = 0;

  aw_hold: assert property (@(posedge clk) disable iff (rst)
    mem_req.awvalid && !mem_rsp.awready |=> mem_req.awvalid && $stable(mem_req.awaddr))
  else begin
    $error("awvalid dropped or awaddr changed before awready");
    fails++;
  end

  w_hold: assert property (@(posedge clk) disable iff (rst)
    mem_req.wvalid && !mem_rsp.wready |=>
      mem_req.wvalid && $stable(mem_req.wdata) && $stable(mem_req.wstrb))
  else begin
    $error("wvalid dropped or write data changed before wready");
    fails++;
  end

  ar_hold: assert property (@(posedge clk) disable iff (rst)
    mem_req.arvalid && !mem_rsp.arready |=> mem_req.arvalid && $stable(mem_req.araddr))
  else begin
    $error("arvalid dropped or araddr changed before arready");
    fails++;
  end

  // registered output, so checked one edge later
  quiet_in_reset: assert property (@(posedge clk) rst |=> !result_valid)
  else begin
    $error("result_valid high during reset");
    fails++;
  end

  one_outstanding: assert property (@(posedge clk) disable iff (rst)
    !((mem_req.arvalid || mem_req.rready) &&
      (mem_req.awvalid || mem_req.wvalid || mem_req.bready)))
  else begin
    $error("read and write outstanding at the same time");
    fails++;
  end

endmodule

bind lsu_top lsu_properties u_lsu_properties (
  .clk          (clk),
  .rst          (rst),
  .mem_req      (mem_req),
  .mem_rsp      (mem_rsp),
  .result_valid (result_valid)
);

`default_nettype wire

// ==== verilog/lsu_top.sv ====
`default_nettype none

module lsu_top
  import lsu_pkg::*;
(
  input  wire           clk,
  input  wire           rst,
  input  wire           req_valid,
  input  lsu_req_t      req,
  output logic          req_ready,
  output axi_lite_req_t mem_req,
  input  axi_lite_rsp_t mem_rsp,
  output logic          result_valid,
  output lsu_result_t   result
);

  mem_op_t   agen_op;
  mem_op_t   op_data;
  logic      op_valid;
  logic      op_ready;

  load_raw_t raw_data;
  logic      raw_valid;
  logic      raw_ready;

  load_raw_t align_data;
  logic      align_valid;
  logic      align_ready;

  addr_gen u_addr_gen (
    .req    (req),
    .op_out (agen_op)
  );

  stage_reg #(
    .payload_t (mem_op_t)
  ) u_agen_reg (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (req_valid),
    .in_data   (agen_op),
    .in_ready  (req_ready),
    .out_valid (op_valid),
    .out_data  (op_data),
    .out_ready (op_ready)
  );

  dcache_access u_dcache_access (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (op_valid),
    .in_op     (op_data),
    .in_ready  (op_ready),
    .out_valid (raw_valid),
    .out_data  (raw_data),
    .out_ready (raw_ready),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp)
  );

  stage_reg #(
    .payload_t (load_raw_t)
  ) u_load_reg (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (raw_valid),
    .in_data   (raw_data),
    .in_ready  (raw_ready),
    .out_valid (align_valid),
    .out_data  (align_data),
    .out_ready (align_ready)
  );

  load_align u_load_align (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (align_valid),
    .in_data      (align_data),
    .in_ready     (align_ready),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

`default_nettype wire

// ==== verilog/load_align.sv ====
`default_nettype none

`include "lsu_cfg.svh"

module load_align
  import lsu_pkg::*;
(
  input  wire         clk,
  input  wire         rst,
  input  wire         in_valid,
  input  load_raw_t   in_data,
  output logic        in_ready,
  output logic        result_valid,
  output lsu_result_t result
);

  logic [`LSU_DATA_W-1:0] lane;
  logic [`LSU_DATA_W-1:0] value;

  // result bus never stalls
  assign in_ready = 1'b1;

  assign lane = in_data.word >> {in_data.offset, 3'b000};

  always_comb begin
    case (in_data.op)
      lsu_lb:  value = {{(`LSU_DATA_W - 8){lane[7]}}, lane[7:0]};
      lsu_lh:  value = {{(`LSU_DATA_W - 16){lane[15]}}, lane[15:0]};
      lsu_lbu: value = {{(`LSU_DATA_W - 8){1'b0}}, lane[7:0]};
      lsu_lhu: value = {{(`LSU_DATA_W - 16){1'b0}}, lane[15:0]};
      default: value = lane;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      result.tag   <= in_data.tag;
      result.value <= value;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dcache_access.sv ====
`default_nettype none

`include "lsu_cfg.svh"

module dcache_access
  import lsu_pkg::*;
(
  input  wire           clk,
  input  wire           rst,
  input  wire           in_valid,
  input  mem_op_t       in_op,
  output logic          in_ready,
  output logic          out_valid,
  output load_raw_t     out_data,
  input  wire           out_ready,
  output axi_lite_req_t mem_req,
  input  axi_lite_rsp_t mem_rsp
);

  localparam int lines       = 1 << `LSU_INDEX_W;
  localparam int cache_tag_w = `LSU_ADDR_W - `LSU_INDEX_W - 2;
  localparam int strb_w      = `LSU_DATA_W / 8;

  typedef enum logic [1:0] {
    st_idle, st_rd_wait, st_wr_addr_data, st_wr_resp
  } state_e;

  state_e state;

  logic [cache_tag_w-1:0] tag_mem [lines];
  logic [`LSU_DATA_W-1:0] data_mem [lines];
  logic [lines-1:0]       valid_mem;

  logic [`LSU_INDEX_W-1:0] index;
  logic [cache_tag_w-1:0]  line_tag;
  logic                    hit;
  logic                    load_hit;
  logic                    refill;
  logic                    store_done;
  logic                    rd_ready;
  logic [strb_w-1:0]       strb;

  logic                   aw_valid;
  logic                   w_valid;
  logic                   ar_valid;
  logic                   aw_pending;
  logic                   w_pending;
  logic [`LSU_ADDR_W-1:0] addr_q;
  logic [`LSU_DATA_W-1:0] wdata_q;
  logic [strb_w-1:0]      wstrb_q;

  assign index    = in_op.addr[`LSU_INDEX_W+1:2];
  assign line_tag = in_op.addr[`LSU_ADDR_W-1:`LSU_INDEX_W+2];
  assign hit      = valid_mem[index] && (tag_mem[index] == line_tag);

  assign load_hit   = (state == st_idle) && in_valid && !in_op.store && hit;
  assign rd_ready   = (state == st_rd_wait) && !ar_valid;
  assign refill     = rd_ready && mem_rsp.rvalid;
  assign store_done = (state == st_wr_resp) && mem_rsp.bvalid;

  // a store leaves only once its response is back
  assign in_ready  = (load_hit && out_ready) || store_done;
  assign out_valid = load_hit;

  always_comb begin
    out_data.op     = in_op.op;
    out_data.offset = in_op.addr[1:0];
    out_data.word   = data_mem[index];
    out_data.tag    = in_op.tag;
  end

  // byte lanes touched by the store
  always_comb begin
    case (in_op.op)
      lsu_sb:  strb = strb_w'(4'b0001) << in_op.addr[1:0];
      lsu_sh:  strb = strb_w'(4'b0011) << in_op.addr[1:0];
      default: strb = '1;
    endcase
  end

  assign aw_pending = aw_valid && !mem_rsp.awready;
  assign w_pending  = w_valid && !mem_rsp.wready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_idle;
      aw_valid  <= 1'b0;
      w_valid   <= 1'b0;
      ar_valid  <= 1'b0;
      valid_mem <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (in_valid && in_op.store) begin
            state    <= st_wr_addr_data;
            aw_valid <= 1'b1;
            w_valid  <= 1'b1;
          end else if (in_valid && !hit) begin
            state    <= st_rd_wait;
            ar_valid <= 1'b1;
          end
        end
        st_rd_wait: begin
          if (ar_valid && mem_rsp.arready) begin
            ar_valid <= 1'b0;
          end
          if (refill) begin
            state            <= st_idle;
            valid_mem[index] <= 1'b1;
          end
        end
        st_wr_addr_data: begin
          aw_valid <= aw_pending;
          w_valid  <= w_pending;
          if (!aw_pending && !w_pending) begin
            state <= st_wr_resp;
          end
        end
        st_wr_resp: begin
          if (mem_rsp.bvalid) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && in_valid) begin
      addr_q  <= {in_op.addr[`LSU_ADDR_W-1:2], 2'b00};
      wdata_q <= in_op.data << {in_op.addr[1:0], 3'b000};
      wstrb_q <= strb;
    end
    if (refill) begin
      tag_mem[index]  <= line_tag;
      data_mem[index] <= mem_rsp.rdata;
    end
    // write-through, the line is only updated when already present
    if (store_done && hit) begin
      for (int i = 0; i < strb_w; i++) begin
        if (wstrb_q[i]) begin
          data_mem[index][8*i +: 8] <= wdata_q[8*i +: 8];
        end
      end
    end
  end

  always_comb begin
    mem_req.awvalid = aw_valid;
    mem_req.awaddr  = addr_q;
    mem_req.wvalid  = w_valid;
    mem_req.wdata   = wdata_q;
    mem_req.wstrb   = wstrb_q;
    mem_req.bready  = (state == st_wr_resp);
    mem_req.arvalid = ar_valid;
    mem_req.araddr  = addr_q;
    mem_req.rready  = rd_ready;
  end

endmodule

`default_nettype wire

// ==== verilog/addr_gen.sv ====
`default_nettype none

`include "lsu_cfg.svh"

module addr_gen
  import lsu_pkg::*;
(
  input  lsu_req_t req,
  output mem_op_t  op_out
);

  localparam int imm_w = $bits(lsu_imm_t);

  logic [`LSU_ADDR_W-1:0] imm_ext;
  logic                   is_store;

  assign imm_ext = {{(`LSU_ADDR_W - imm_w){req.imm[imm_w-1]}}, req.imm};

  // operation class
  always_comb begin
    case (req.op)
      lsu_sb, lsu_sh, lsu_sw: is_store = 1'b1;
      default:                is_store = 1'b0;
    endcase
  end

  always_comb begin
    op_out.op    = req.op;
    op_out.addr  = req.base + imm_ext;
    // rs2 value, only meaningful for stores
    op_out.data  = req.data;
    op_out.tag   = req.tag;
    op_out.store = is_store;
  end

endmodule

`default_nettype wire

// ==== verilog/stage_reg.sv ====
`default_nettype none

module stage_reg #(
  parameter type payload_t = logic
) (
  input  wire      clk,
  input  wire      rst,
  input  wire      in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data,
  input  wire      out_ready
);

  logic full;
  // low for the first cycle after reset
  logic live;

  assign in_ready  = live && (!full || out_ready);
  assign out_valid = full;

  always_ff @(posedge clk) begin
    if (rst) begin
      live <= 1'b0;
      full <= 1'b0;
    end else begin
      live <= 1'b1;
      if (in_valid && in_ready) begin
        full <= 1'b1;
      end else if (out_ready) begin
        full <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_data <= in_data;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/lsu_pkg.sv ====
`default_nettype none

`include "lsu_cfg.svh"

package lsu_pkg;

  typedef enum logic [2:0] {
    lsu_lb, lsu_lh, lsu_lw, lsu_lbu, lsu_lhu,
    lsu_sb, lsu_sh, lsu_sw
  } lsu_op_e;

  // i-type / s-type immediate
  typedef logic [11:0] lsu_imm_t;

  typedef struct packed {
    lsu_op_e                op;
    logic [`LSU_ADDR_W-1:0] base;
    lsu_imm_t               imm;
    logic [`LSU_DATA_W-1:0] data;
    logic [`LSU_TAG_W-1:0]  tag;
  } lsu_req_t;

  typedef struct packed {
    lsu_op_e                op;
    logic [`LSU_ADDR_W-1:0] addr;
    logic [`LSU_DATA_W-1:0] data;
    logic [`LSU_TAG_W-1:0]  tag;
    logic                   store;
  } mem_op_t;

  typedef struct packed {
    lsu_op_e                op;
    logic [1:0]             offset;
    logic [`LSU_DATA_W-1:0] word;
    logic [`LSU_TAG_W-1:0]  tag;
  } load_raw_t;

  typedef struct packed {
    logic [`LSU_TAG_W-1:0]  tag;
    logic [`LSU_DATA_W-1:0] value;
  } lsu_result_t;

  typedef struct packed {
    logic                     awvalid;
    logic [`LSU_ADDR_W-1:0]   awaddr;
    logic                     wvalid;
    logic [`LSU_DATA_W-1:0]   wdata;
    logic [`LSU_DATA_W/8-1:0] wstrb;
    logic                     bready;
    logic                     arvalid;
    logic [`LSU_ADDR_W-1:0]   araddr;
    logic                     rready;
  } axi_lite_req_t;

  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    logic                   arready;
    logic                   rvalid;
    logic [`LSU_DATA_W-1:0] rdata;
  } axi_lite_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/lsu_cfg.svh ====
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// address and data paths
`define LSU_ADDR_W 32
`define LSU_DATA_W 32

// destination tag, one reorder-buffer id
`define LSU_TAG_W 5

// direct-mapped cache, one word per line
`define LSU_INDEX_W 4

`endif
